/* include/telemetry_cfg.svh */
`ifndef TELEMETRY_CFG_SVH
`define TELEMETRY_CFG_SVH

// clock cycles per serial bit, 2 or more
`define TLM_CLK_PER_BIT 8

// bytes sent per record
`define TLM_FRAME_BYTES 6

// record width in bits
`define TLM_RECORD_BITS 48

`endif

/* src/telemetry_pkg.sv */
`default_nettype none
`include "telemetry_cfg.svh"

package telemetry_pkg;

    typedef logic [`TLM_RECORD_BITS-1:0] record_word_t;

    typedef logic [7:0] seq_t;

    typedef enum logic {
        KIND_SAMPLE = 1'b0,
        KIND_STATUS = 1'b1
    } kind_e;

    // accelerometer style sample
    typedef struct packed {
        kind_e       kind;
        logic [14:0] x;
        logic [15:0] y;
        logic [15:0] z;
    } sample_t;

    typedef struct packed {
        kind_e       kind;
        logic [6:0]  code;
        seq_t        seq;
        logic [31:0] uptime;
    } status_t;

    // same 48 bits, view picked by kind
    typedef union packed {
        sample_t sample;
        status_t status;
    } record_u;

endpackage

`default_nettype wire

/* src/record_capture.sv */
`default_nettype none

module record_capture import telemetry_pkg::*; (
    input  wire          clk,
    input  wire          rst,
    input  wire          rec_req,
    input  wire record_word_t rec_data,
    output logic         rec_ack,
    input  wire          buf_take,
    output logic         buf_valid,
    output record_word_t buf_data
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_ACKED,
        S_WAIT_DROP
    } state_t;

    state_t state;
    logic   accept;

    // only acknowledge into an empty buffer, producer stalls otherwise
    assign accept = (state == S_IDLE) && rec_req && !buf_valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= S_IDLE;
            rec_ack   <= 1'b0;
            buf_valid <= 1'b0;
        end else begin
            if (buf_take) begin
                buf_valid <= 1'b0;
            end
            case (state)
                S_IDLE: begin
                    if (accept) begin
                        rec_ack   <= 1'b1;
                        buf_valid <= 1'b1;
                        state     <= S_ACKED;
                    end
                end
                S_ACKED, S_WAIT_DROP: begin
                    // ack held until req seen low
                    if (!rec_req) begin
                        rec_ack <= 1'b0;
                        state   <= S_IDLE;
                    end else begin
                        state <= S_WAIT_DROP;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            buf_data <= rec_data;
        end
    end

endmodule

`default_nettype wire

/* src/record_formatter.sv */
`default_nettype none

module record_formatter import telemetry_pkg::*; (
    input  wire          clk,
    input  wire          rst,
    input  wire          buf_valid,
    input  wire record_word_t buf_data,
    output logic         buf_take,
    input  wire          busy,
    output logic         start,
    output record_word_t frame_data
);

    record_u rec_in;
    record_u rec_out;
    seq_t    seq_cnt;
    logic    out_valid;
    logic    is_status;

    assign rec_in    = buf_data;
    assign is_status = (rec_in.status.kind == KIND_STATUS);

    // sample records pass as they are
    always_comb begin
        rec_out = rec_in;
        if (is_status) begin
            rec_out.status.seq = seq_cnt;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            buf_take  <= 1'b0;
            start     <= 1'b0;
            out_valid <= 1'b0;
            seq_cnt   <= '0;
        end else begin
            buf_take <= buf_valid && !out_valid && !buf_take;
            start    <= out_valid && !busy && !start;
            if (buf_take) begin
                out_valid <= 1'b1;
                // counts status records only
                if (is_status) begin
                    seq_cnt <= seq_cnt + 1'b1;
                end
            end else if (start) begin
                out_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (buf_take) begin
            frame_data <= rec_out;
        end
    end

endmodule

`default_nettype wire

/* src/frame_tx.sv */
`default_nettype none
`include "telemetry_cfg.svh"

module frame_tx import telemetry_pkg::*; (
    input  wire          clk,
    input  wire          rst,
    input  wire          hold,
    input  wire          start,
    input  wire record_word_t frame_data,
    output logic         tx,
    output logic         busy
);

    localparam int CTR_W  = $clog2(`TLM_CLK_PER_BIT);
    localparam int BYTE_W = $clog2(`TLM_FRAME_BYTES);

    localparam logic [CTR_W-1:0]  CTR_LAST  = CTR_W'(`TLM_CLK_PER_BIT - 1);
    localparam logic [BYTE_W-1:0] BYTE_LAST = BYTE_W'(`TLM_FRAME_BYTES - 1);

    typedef enum logic [1:0] {
        S_IDLE,
        S_START,
        S_DATA,
        S_STOP
    } state_t;

    state_t            state;
    logic [CTR_W-1:0]  ctr;
    logic [2:0]        bit_idx;
    logic [BYTE_W-1:0] byte_cnt;
    logic              hold_q;
    logic              bit_end;
    record_word_t      shreg;

    assign bit_end = (ctr == CTR_LAST);

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= S_IDLE;
            ctr      <= '0;
            bit_idx  <= '0;
            byte_cnt <= '0;
            hold_q   <= 1'b0;
            tx       <= 1'b1;
            busy     <= 1'b0;
        end else begin
            hold_q <= hold;
            case (state)
                S_IDLE: begin
                    ctr      <= '0;
                    bit_idx  <= '0;
                    byte_cnt <= '0;
                    // start only arrives while busy is low, so always honour it
                    if (start) begin
                        state <= S_START;
                        tx    <= 1'b0;
                        busy  <= 1'b1;
                    end else begin
                        busy <= hold_q;
                    end
                end
                S_START: begin
                    ctr <= ctr + 1'b1;
                    if (bit_end) begin
                        ctr   <= '0;
                        state <= S_DATA;
                        tx    <= shreg[0];
                    end
                end
                S_DATA: begin
                    ctr <= ctr + 1'b1;
                    if (bit_end) begin
                        ctr     <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= S_STOP;
                            tx    <= 1'b1;
                        end else begin
                            // next bit is at [1] before the shift lands
                            tx <= shreg[1];
                        end
                    end
                end
                S_STOP: begin
                    ctr <= ctr + 1'b1;
                    if (bit_end) begin
                        ctr <= '0;
                        if (byte_cnt == BYTE_LAST) begin
                            state <= S_IDLE;
                            busy  <= hold_q;
                        end else begin
                            byte_cnt <= byte_cnt + 1'b1;
                            state    <= S_START;
                            tx       <= 1'b0;
                        end
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // record shifts right one bit per data bit, lsb byte first
    always_ff @(posedge clk) begin
        if (state == S_IDLE && start) begin
            shreg <= frame_data;
        end else if (state == S_DATA && bit_end) begin
            shreg <= shreg >> 1;
        end
    end

endmodule

`default_nettype wire

/* src/telemetry_uart.sv */
`default_nettype none

module telemetry_uart import telemetry_pkg::*; (
    input  wire          clk,
    input  wire          rst,
    input  wire          rec_req,
    input  wire record_word_t rec_data,
    output logic         rec_ack,
    input  wire          hold,
    output logic         tx,
    output logic         busy
);

    logic         buf_valid;
    logic         buf_take;
    record_word_t buf_data;
    logic         start;
    record_word_t frame_data;

    record_capture u_record_capture (
        .clk       (clk),
        .rst       (rst),
        .rec_req   (rec_req),
        .rec_data  (rec_data),
        .rec_ack   (rec_ack),
        .buf_take  (buf_take),
        .buf_valid (buf_valid),
        .buf_data  (buf_data)
    );

    record_formatter u_record_formatter (
        .clk        (clk),
        .rst        (rst),
        .buf_valid  (buf_valid),
        .buf_data   (buf_data),
        .buf_take   (buf_take),
        .busy       (busy),
        .start      (start),
        .frame_data (frame_data)
    );

    frame_tx u_frame_tx (
        .clk        (clk),
        .rst        (rst),
        .hold       (hold),
        .start      (start),
        .frame_data (frame_data),
        .tx         (tx),
        .busy       (busy)
    );

endmodule

`default_nettype wire

/* testbench/telemetry_props.sv */
`default_nettype none

module telemetry_props (
    input wire clk,
    input wire rst,
    input wire rec_req,
    input wire rec_ack,
    input wire tx,
    input wire busy
);

    timeunit 1ns;
    timeprecision 100ps;

    // read by the testbench for its verdict
    int fail_count = 0;

    ack_rise: assert property (@(posedge clk) disable iff (rst)
        $rose(rec_ack) |-> $past(rec_req))
        else begin
            fail_count++;
            $error("rec_ack rose while rec_req was low");
        end

    ack_fall: assert property (@(posedge clk) disable iff (rst)
        $fell(rec_ack) |-> !$past(rec_req))
        else begin
            fail_count++;
            $error("rec_ack fell before rec_req dropped");
        end

    // idle line is always marking
    idle_line: assert property (@(posedge clk) disable iff (rst) !busy |-> tx)
        else begin
            fail_count++;
            $error("tx low while busy is low");
        end

endmodule

bind telemetry_uart telemetry_props u_telemetry_props (.*);

`default_nettype wire

/* testbench/telemetry_monitor.sv */
`default_nettype none
`include "telemetry_cfg.svh"

module telemetry_monitor import telemetry_pkg::*; (
    input  wire  clk,
    input  wire  rst,
    input  wire  tx,
    input  wire  hold,
    input  wire  rec_req,
    input  wire  rec_ack,
    output int   frames_seen,
    output int   error_count,
    output logic done
);

    timeunit 1ns;
    timeprecision 100ps;

    localparam int CPB = `TLM_CLK_PER_BIT;

    record_word_t expected_q[$];
    logic         loaded = 1'b0;
    int           frame_errors = 0;
    int           idle_errors;
    int           hold_run;
    logic         req_seen;

    assign error_count = frame_errors + idle_errors;

    initial begin : read_expected
        integer           fd;
        integer           n;
        integer           hold_cycles;
        record_word_t     word_in;
        record_word_t     word_exp;
        logic [8*128-1:0] line;
        fd = $fopen("testbench/telemetry_tests.txt", "r");
        while (fd != 0 && !$feof(fd)) begin
            n = $fscanf(fd, "%h %d %h\n", word_in, hold_cycles, word_exp);
            if (n == 3) begin
                expected_q.push_back(word_exp);
            end else if (n >= 0) begin
                n = $fgets(line, fd);
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end
        loaded = 1'b1;
    end

    // consecutive cycles with hold high
    always @(posedge clk) begin
        if (rst || !hold) begin
            hold_run <= 0;
        end else begin
            hold_run <= hold_run + 1;
        end
    end

    // quiet line until the first request
    always @(negedge clk) begin
        if (rst) begin
            req_seen    <= 1'b0;
            idle_errors <= 0;
        end else if (!req_seen) begin
            if (rec_req) begin
                req_seen <= 1'b1;
            end else if (rec_ack !== 1'b0 || tx !== 1'b1) begin
                $display("[ERROR] %0t rec_ack got %b expected 0, tx got %b expected 1",
                         $time, rec_ack, tx);
                idle_errors <= idle_errors + 1;
            end
        end
    end

    initial begin : decode_frames
        record_word_t word;
        logic [9:0]   bits;
        logic         framing_bad;
        int           passed;
        frames_seen = 0;
        passed      = 0;
        done        = 1'b0;
        wait (loaded);
        while (frames_seen < expected_q.size()) begin
            framing_bad = 1'b0;
            for (int b = 0; b < `TLM_FRAME_BYTES; b++) begin
                @(negedge clk);
                while (rst || tx !== 1'b0) begin
                    @(negedge clk);
                end
                // hold seen at least three edges back blocks any new frame
                if (b == 0 && hold_run >= 4) begin
                    $display("%0t a frame started while hold was high", $time);
                    frame_errors++;
                end
                repeat (CPB / 2 - 1) @(negedge clk);
                for (int k = 0; k < 10; k++) begin
                    if (k > 0) begin
                        repeat (CPB) @(negedge clk);
                    end
                    bits[k] = tx;
                end
                if (bits[0] !== 1'b0 || bits[9] !== 1'b1) begin
                    $display("test %0d failed: framing error in byte %0d, start bit %b stop bit %b",
                             frames_seen, b, bits[0], bits[9]);
                    framing_bad = 1'b1;
                end
                word[8*b +: 8] = bits[8:1];
            end
            if (framing_bad) begin
                frame_errors++;
            end else if (word !== expected_q[frames_seen]) begin
                $display("[ERROR] %0t tx_word got %h expected %h",
                         $time, word, expected_q[frames_seen]);
                frame_errors++;
            end else begin
                $display("test %0d passed, tx_word %h", frames_seen, word);
                passed++;
            end
            frames_seen++;
        end
        $display("monitor: %0d tests, %0d passed, %0d failed, %0d other errors",
                 frames_seen, passed, frames_seen - passed, error_count - (frames_seen - passed));
        done = 1'b1;
    end

endmodule

`default_nettype wire

/* testbench/tb_telemetry_uart.sv */
`default_nettype none
`include "telemetry_cfg.svh"

module tb_telemetry_uart import telemetry_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int CPB          = `TLM_CLK_PER_BIT;
    localparam int RESET_CYCLES = 16;

    logic         clk;
    logic         rst;
    logic         rec_req;
    record_word_t rec_data;
    logic         rec_ack;
    logic         hold;
    logic         tx;
    logic         busy;
    int           frames_seen;
    int           error_count;
    logic         mon_done;
    record_word_t word_q[$];
    int           hold_cycles_q[$];
    int           limit = 0;
    integer       seed;

    telemetry_uart u_telemetry_uart (
        .clk      (clk),
        .rst      (rst),
        .rec_req  (rec_req),
        .rec_data (rec_data),
        .rec_ack  (rec_ack),
        .hold     (hold),
        .tx       (tx),
        .busy     (busy)
    );

    telemetry_monitor u_telemetry_monitor (
        .clk         (clk),
        .rst         (rst),
        .tx          (tx),
        .hold        (hold),
        .rec_req     (rec_req),
        .rec_ack     (rec_ack),
        .frames_seen (frames_seen),
        .error_count (error_count),
        .done        (mon_done)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin : watchdog
        wait (limit > 0);
        repeat (limit) @(posedge clk);
        $display("run timed out after %0d cycles without all frames", limit);
        $display("*** TEST FAILED ***");
        $finish;
    end

    // four-phase producer side
    task automatic send_record(input record_word_t word);
        rec_data <= word;
        rec_req  <= 1'b1;
        @(posedge clk);
        while (!rec_ack) @(posedge clk);
        rec_req <= 1'b0;
        @(posedge clk);
        while (rec_ack) @(posedge clk);
    endtask

    initial begin : drive
        integer           fd;
        integer           n;
        integer           hcyc;
        record_word_t     w_in;
        record_word_t     w_exp;
        logic [8*128-1:0] line;
        int               hold_sum;
        seed     = 99;
        hold_sum = 0;
        rst      <= 1'b1;
        rec_req  <= 1'b0;
        rec_data <= '0;
        hold     <= 1'b0;
        fd = $fopen("testbench/telemetry_tests.txt", "r");
        while (fd != 0 && !$feof(fd)) begin
            n = $fscanf(fd, "%h %d %h\n", w_in, hcyc, w_exp);
            if (n == 3) begin
                word_q.push_back(w_in);
                hold_cycles_q.push_back(hcyc);
                hold_sum += hcyc;
            end else if (n >= 0) begin
                n = $fgets(line, fd);
            end
        end
        limit = word_q.size() * 60 * CPB * 2 + RESET_CYCLES + hold_sum;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        repeat (4) @(posedge clk);
        foreach (word_q[i]) begin
            repeat ($unsigned($random(seed)) % 4) @(posedge clk);
            // hold only goes up once the link has drained
            if (hold_cycles_q[i] > 0) begin
                while (frames_seen != i || busy) @(posedge clk);
                hold <= 1'b1;
            end
            // hold pulse runs alongside the handshake
            fork
                send_record(word_q[i]);
                if (hold_cycles_q[i] > 0) begin
                    repeat (hold_cycles_q[i]) @(posedge clk);
                    hold <= 1'b0;
                end
            join
        end
        wait (mon_done);
        if (word_q.size() == 0) begin
            $display("no tests were read from the data file");
        end
        if (error_count == 0 && u_telemetry_uart.u_telemetry_props.fail_count == 0
                && word_q.size() > 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* testbench/telemetry_tests.txt */
# columns: input word (hex), hold cycles (dec), expected tx word (hex)
# status words (bit 47 set) carry the link sequence number in bits 39..32
0123456789ab 0 0123456789ab
7fffffffffff 0 7fffffffffff
85aa00001234 0 850000001234
000000000000 0 000000000000
9fffdeadbeef 0 9f01deadbeef
3c3c5a5aa5a5 0 3c3c5a5aa5a5
80ff00000000 0 800200000000
555555555555 20 555555555555
c17700000001 30 c10300000001
7a5b1c2d3e4f 0 7a5b1c2d3e4f
ff00ffffffff 0 ff04ffffffff
000100020003 0 000100020003

/* telemetry_uart.f */
+incdir+include
src/telemetry_pkg.sv
src/record_capture.sv
src/record_formatter.sv
src/frame_tx.sv
src/telemetry_uart.sv
testbench/telemetry_props.sv
testbench/telemetry_monitor.sv
testbench/tb_telemetry_uart.sv

/* run_sim.sh */
#!/bin/sh
# build with Verilator, run, and look for the pass line in the output
verilator --binary --assert --timescale 1ns/100ps --top-module tb_telemetry_uart \
    -f telemetry_uart.f \
    && ./obj_dir/Vtb_telemetry_uart +verilator+error+limit+100 | tee /dev/stderr \
    | grep -qF '*** TEST PASSED ***' \
    || { echo "simulation failed"; exit 1; }
